// File: compile.f
+incdir+include
hdl/fb_pkg.sv
hdl/frame_cell.sv
hdl/frame_buffer.sv
hdl/pixel_fifo.sv
hdl/fb_top.sv
dv/tb_fb_top.sv

// File: dv/fb_stimulus.txt
# base colour, gap mask, drain stall mask, all hex
# one line per frame, frames alternate between cell 0 and cell 1
3 00 00
5 11 0f
0 ff 00
7 24 fc
2 81 3f
6 00 7e
1 5a 18
4 0f c0
6 e7 f6
2 33 a5

// File: dv/tb_fb_top.sv
`timescale 1ns/1ps
`include "fb_config.svh"

module tb_fb_top
	import fb_pkg::*;
();

	localparam int npix = `FB_WIDTH * `FB_HEIGHT;
	localparam int idx_bits = $clog2(npix);
	localparam int wait_limit = 4000;

	logic clk;
	logic rst_n;
	logic rast_valid;
	rast_pixel_t rast_pixel;
	logic rast_done;
	logic rast_ready;
	logic out_valid;
	scan_pixel_t out_pixel;
	logic out_ready;

	// frame rows from the stimulus file
	logic [7:0] base_q[$];
	logic [7:0] gap_q[$];
	logic [7:0] stall_q[$];
	logic [7:0] cur_stall;
	logic [31:0] rast_lfsr;
	logic [31:0] drain_lfsr;

	// reference model, finished frames wait here until their swap shows up
	logic done_ids[$];
	logic [2:0] done_bases[$];
	logic [2:0] shown_base [2];
	logic last_tag;
	logic in_frame;
	int pos;
	int frames_seen;
	int switches;
	int checks;
	int errors;
	int timeouts;

	fb_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// 32-bit fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	task automatic take_bits(inout logic [31:0] st, input int n, output int v);
		int k;
		v = 0;
		for (k = 0; k < n; k++) begin
			v = (v << 1) | int'(st[0]);
			st = lfsr_next(st);
		end
	endtask

	task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR @%0t: %s, got %0h expected %0h", $time, msg, got, exp);
		end
	endtask

	task automatic report_and_finish();
		$display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	task automatic stop_on_timeout(input string why);
		timeouts++;
		$display("timeout: %s", why);
		report_and_finish();
	endtask

	// one popped output pixel against the reference
	task automatic record_pixel(input scan_pixel_t px);
		color_t exp_color;
		if (px.sof === 1'b1) begin
			// a new tag means a swap, which needs a finished frame behind it
			if (px.buf_id !== last_tag) begin
				check_val(32'(done_ids.size() != 0), 32'd1,
					"frame start with a new tag before rast_done");
				if (done_ids.size() != 0) begin
					check_val(32'(px.buf_id), 32'(done_ids.pop_front()), "tag after swap");
					shown_base[px.buf_id] = done_bases.pop_front();
				end
				switches++;
				last_tag = px.buf_id;
			end
			// whole frame between two starts
			if (in_frame) begin
				check_val(32'(pos), 32'(npix), "pixels per frame");
				frames_seen++;
			end
			if (switches > 0) begin
				in_frame = 1'b1;
			end
			pos = 0;
		end
		if (in_frame) begin
			check_val(32'(px.buf_id), 32'(last_tag), "tag within frame");
			exp_color = color_t'(int'(shown_base[last_tag]) + pos % `FB_WIDTH + pos / `FB_WIDTH);
			check_val(32'(px.color), 32'(exp_color), "pixel colour");
			pos++;
		end
	endtask

	// display side, stalls picked by the stall mask
	task automatic run_drain();
		int r;
		logic [2:0] sel;
		logic ready;
		forever begin
			@(negedge clk);
			take_bits(drain_lfsr, 3, r);
			sel = 3'(r);
			ready = !cur_stall[sel];
			out_ready = ready;
			// fifo head is stable here and pops at the next rising edge
			if (out_valid === 1'b1 && ready) begin
				record_pixel(out_pixel);
			end
		end
	endtask

	// rasterizer, every pixel once in shuffled order
	task automatic draw_frame(input int f, input logic [2:0] base, input logic [7:0] gap);
		int perm [npix];
		int i;
		int j;
		int t;
		int r;
		int held;
		int waited;
		logic [2:0] sel;
		for (i = 0; i < npix; i++) begin
			perm[i] = i;
		end
		// fisher-yates
		for (i = npix - 1; i > 0; i--) begin
			take_bits(rast_lfsr, idx_bits, r);
			j = r % (i + 1);
			t = perm[i];
			perm[i] = perm[j];
			perm[j] = t;
		end
		held = 0;
		for (i = 0; i < npix; i++) begin
			take_bits(rast_lfsr, 3, r);
			sel = 3'(r);
			// no gap before the first pixel so it meets the held-off window
			if (i > 0 && gap[sel]) begin
				rast_valid = 1'b0;
				@(negedge clk);
			end
			rast_pixel.x = coord_x_t'(perm[i] % `FB_WIDTH);
			rast_pixel.y = coord_y_t'(perm[i] / `FB_WIDTH);
			rast_pixel.color = color_t'(int'(base) + perm[i] % `FB_WIDTH + perm[i] / `FB_WIDTH);
			rast_valid = 1'b1;
			waited = 0;
			while (rast_ready !== 1'b1) begin
				held++;
				waited++;
				if (waited > wait_limit) stop_on_timeout("rast_ready stayed low during a write");
				@(negedge clk);
			end
			@(negedge clk);
		end
		rast_valid = 1'b0;
		rast_done = 1'b1;
		done_ids.push_back(f[0]);
		done_bases.push_back(base);
		@(negedge clk);
		rast_done = 1'b0;
		check_val(32'(rast_ready), 32'd0, "rast_ready after rast_done");
		if (f > 0) check_val(32'(held > 0), 32'd1, "attempt held until swap");
	endtask

	initial begin
		int fd;
		int rc;
		int f;
		int waited;
		int target;
		string line;
		logic [7:0] b;
		logic [7:0] g;
		logic [7:0] s;
		rst_n = 1'b0;
		rast_valid = 1'b0;
		rast_pixel = '0;
		rast_done = 1'b0;
		out_ready = 1'b0;
		cur_stall = '0;
		rast_lfsr = 32'h448d;
		drain_lfsr = 32'h448d;
		last_tag = 1'b1;
		in_frame = 1'b0;
		pos = 0;
		frames_seen = 0;
		switches = 0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		fd = $fopen("dv/fb_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open dv/fb_stimulus.txt");
			report_and_finish();
		end
		while (!$feof(fd)) begin
			rc = $fgets(line, fd);
			if (rc > 0 && line[0] != "#" && $sscanf(line, "%h %h %h", b, g, s) == 3) begin
				base_q.push_back(b);
				gap_q.push_back(g);
				stall_q.push_back(s);
			end
		end
		$fclose(fd);
		check_val(32'(base_q.size() > 0), 32'd1, "frames in stimulus");
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_val(32'(rast_ready), 32'd1, "rast_ready after reset");
		check_val(32'(out_valid), 32'd0, "out_valid after reset");
		fork
			run_drain();
		join_none
		for (f = 0; f < base_q.size(); f++) begin
			cur_stall = stall_q[f];
			draw_frame(f, base_q[f][2:0], gap_q[f]);
		end
		// last swap, then two more frame starts so the last frame is counted
		waited = 0;
		while (rast_ready !== 1'b1 || done_ids.size() != 0) begin
			waited++;
			if (waited > wait_limit) stop_on_timeout("last frame never reached the display");
			@(negedge clk);
		end
		target = frames_seen + 2;
		waited = 0;
		while (frames_seen < target) begin
			waited++;
			if (waited > wait_limit) stop_on_timeout("output stopped after the last swap");
			@(negedge clk);
		end
		check_val(32'(switches), 32'(base_q.size()), "buffer swaps seen");
		report_and_finish();
	end

endmodule

// File: hdl/fb_pkg.sv
`include "fb_config.svh"

package fb_pkg;

	// pixel column and row
	typedef logic [`FB_X_BITS-1:0] coord_x_t;
	typedef logic [`FB_Y_BITS-1:0] coord_y_t;

	// 3-bit colour, one bit per channel
	typedef logic [2:0] color_t;

	// one pixel from the rasterizer
	typedef struct packed {
		color_t color;
		coord_x_t x;
		coord_y_t y;
	} rast_pixel_t;

	// one pixel toward the display, tagged with source cell and frame start
	typedef struct packed {
		color_t color;
		logic buf_id;
		logic sof;
	} scan_pixel_t;

	// buffer swap handshake
	typedef enum logic [1:0] {idle, pending, swapped_hold} swap_state_t;

endpackage

// File: hdl/fb_top.sv
`timescale 1ns/1ps

module fb_top
	import fb_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic rast_valid,
	input rast_pixel_t rast_pixel,
	input logic rast_done,
	output logic rast_ready,
	output logic out_valid,
	output scan_pixel_t out_pixel,
	input logic out_ready
);

	// scan path between the frame store and the output fifo
	logic scan_valid;
	scan_pixel_t scan_pixel;
	logic fifo_full;

	frame_buffer u_frame_buffer (
		.clk(clk),
		.rst_n(rst_n),
		.rast_valid(rast_valid),
		.rast_pixel(rast_pixel),
		.rast_done(rast_done),
		.rast_ready(rast_ready),
		.fifo_full(fifo_full),
		.scan_valid(scan_valid),
		.scan_pixel(scan_pixel)
	);

	// every scanned pixel is pushed, early full keeps room for it
	pixel_fifo u_pixel_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(scan_valid),
		.push_pixel(scan_pixel),
		.fifo_full(fifo_full),
		.out_valid(out_valid),
		.out_pixel(out_pixel),
		.out_ready(out_ready)
	);

endmodule

// File: hdl/frame_buffer.sv
`timescale 1ns/1ps
`include "fb_config.svh"

module frame_buffer
	import fb_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic rast_valid,
	input rast_pixel_t rast_pixel,
	input logic rast_done,
	output logic rast_ready,
	input logic fifo_full,
	output logic scan_valid,
	output scan_pixel_t scan_pixel
);

	// cell that the rasterizer draws into, the other one is on screen
	logic back_sel;
	swap_state_t swap_state;

	// raster scan position of the front cell
	coord_x_t scan_x;
	coord_y_t scan_y;
	logic scan_adv;
	logic scan_last_x;
	logic scan_last_y;
	logic scan_wrap;

	// cell write enables and read data
	logic we0;
	logic we1;
	color_t rdata0;
	color_t rdata1;

	// front select and frame start captured with the read address
	logic front_q;
	logic sof_q;

	// held off only while a finished frame waits for the scan wrap
	assign rast_ready = (swap_state != pending);

	// writes go to the back cell only
	assign we0 = rast_valid && rast_ready && !back_sel;
	assign we1 = rast_valid && rast_ready && back_sel;

	// scan moves whenever the fifo has room for the pixel in flight
	assign scan_adv = !fifo_full;
	assign scan_last_x = (scan_x == coord_x_t'(`FB_WIDTH - 1));
	assign scan_last_y = (scan_y == coord_y_t'(`FB_HEIGHT - 1));
	assign scan_wrap = scan_adv && scan_last_x && scan_last_y;

	// swap control
	// rast_done arms the swap and the next scan wrap flips the cells
	// swapped_hold marks the first cycle on the new back cell
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			swap_state <= idle;
			back_sel <= 1'b0;
		end else begin
			case (swap_state)
				idle: begin
					if (rast_done) begin
						swap_state <= pending;
					end
				end
				pending: begin
					if (scan_wrap) begin
						back_sel <= ~back_sel;
						swap_state <= swapped_hold;
					end
				end
				swapped_hold: begin
					swap_state <= rast_done ? pending : idle;
				end
				default: begin
					swap_state <= idle;
				end
			endcase
		end
	end

	// raster order scan counters, stalled by fifo_full
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			scan_x <= '0;
			scan_y <= '0;
		end else if (scan_adv) begin
			if (scan_last_x) begin
				scan_x <= '0;
				scan_y <= scan_last_y ? '0 : scan_y + coord_y_t'(1);
			end else begin
				scan_x <= scan_x + coord_x_t'(1);
			end
		end
	end

	// one read in flight, valid follows the address by a cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			scan_valid <= 1'b0;
		end else begin
			scan_valid <= scan_adv;
		end
	end

	// tag captured with the address so the last pixel keeps the old id across a swap
	always_ff @(posedge clk) begin
		if (scan_adv) begin
			front_q <= ~back_sel;
			sof_q <= (scan_x == '0) && (scan_y == '0);
		end
	end

	// pick the front cell data and attach the tag
	always_comb begin
		scan_pixel.color = front_q ? rdata1 : rdata0;
		scan_pixel.buf_id = front_q;
		scan_pixel.sof = sof_q;
	end

	frame_cell u_cell0 (
		.clk(clk),
		.we(we0),
		.waddr_x(rast_pixel.x),
		.waddr_y(rast_pixel.y),
		.wdata(rast_pixel.color),
		.raddr_x(scan_x),
		.raddr_y(scan_y),
		.rdata(rdata0)
	);

	frame_cell u_cell1 (
		.clk(clk),
		.we(we1),
		.waddr_x(rast_pixel.x),
		.waddr_y(rast_pixel.y),
		.wdata(rast_pixel.color),
		.raddr_x(scan_x),
		.raddr_y(scan_y),
		.rdata(rdata1)
	);

	// the rasterizer is let back in only on the edge that swapped the cells
	a_ready_after_swap: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(rast_ready) |-> (back_sel != $past(back_sel)));

	// the tag only changes where a new frame starts
	a_tag_steady: assert property (@(posedge clk) disable iff (!rst_n)
		(scan_valid && !scan_pixel.sof) |-> (scan_pixel.buf_id == $past(scan_pixel.buf_id)));

	// only one finished frame may wait for the swap
	a_done_once: assert property (@(posedge clk) disable iff (!rst_n)
		(swap_state == pending) |-> !rast_done);

endmodule

// File: hdl/frame_cell.sv
`timescale 1ns/1ps
`include "fb_config.svh"

module frame_cell
	import fb_pkg::*;
(
	input logic clk,
	input logic we,
	input coord_x_t waddr_x,
	input coord_y_t waddr_y,
	input color_t wdata,
	input coord_x_t raddr_x,
	input coord_y_t raddr_y,
	output color_t rdata
);

	localparam int cell_depth = `FB_WIDTH * `FB_HEIGHT;
	localparam int addr_bits = $clog2(cell_depth);

	color_t mem [cell_depth];

	logic [addr_bits-1:0] waddr;
	logic [addr_bits-1:0] raddr;

	// row major layout, row times width plus column
	assign waddr = addr_bits'(waddr_y) * addr_bits'(`FB_WIDTH) + addr_bits'(waddr_x);
	assign raddr = addr_bits'(raddr_y) * addr_bits'(`FB_WIDTH) + addr_bits'(raddr_x);

	// write lands at the accepting edge
	// read data shows up one cycle after the address
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];
	end

endmodule

// File: hdl/pixel_fifo.sv
`timescale 1ns/1ps
`include "fb_config.svh"

module pixel_fifo
	import fb_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic push,
	input scan_pixel_t push_pixel,
	output logic fifo_full,
	output logic out_valid,
	output scan_pixel_t out_pixel,
	input logic out_ready
);

	localparam int depth = `FB_FIFO_DEPTH;
	localparam int ptr_bits = `FB_FIFO_PTR_BITS;

	scan_pixel_t mem [depth];

	logic [ptr_bits-1:0] wr_ptr;
	logic [ptr_bits-1:0] rd_ptr;
	logic [ptr_bits:0] count;
	logic pop;

	// wrap at depth so a non power of two depth also works
	function automatic logic [ptr_bits-1:0] ptr_inc(input logic [ptr_bits-1:0] p);
		if (p == ptr_bits'(depth - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	// fall through, head word is visible as soon as count is nonzero
	assign out_valid = (count != '0);
	assign out_pixel = mem[rd_ptr];
	assign pop = out_valid && out_ready;

	// one slot of margin for the pixel already in the read pipeline
	assign fifo_full = (count >= (ptr_bits + 1)'(depth - 1));

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_pixel;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			// count tracks push minus pop
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// early full must keep the scan from ever overrunning the storage
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> (count != (ptr_bits + 1)'(depth)));

	// an empty fifo has its read and write pointers together
	a_empty_ptrs: assert property (@(posedge clk) disable iff (!rst_n)
		(count == '0) |-> (wr_ptr == rd_ptr));

endmodule

// File: include/fb_config.svh
`ifndef FB_CONFIG_SVH
`define FB_CONFIG_SVH

// frame size in pixels
// small default keeps a full frame scan short in simulation
`define FB_WIDTH 8
`define FB_HEIGHT 6

// coordinate widths
// must hold FB_WIDTH-1 and FB_HEIGHT-1
// use 10 and 9 for a 640 by 480 frame
`define FB_X_BITS 3
`define FB_Y_BITS 3

// output fifo depth in pixels
`define FB_FIFO_DEPTH 8

// fifo pointer width, log2 of the depth
`define FB_FIFO_PTR_BITS 3

`endif

// File: run_sim.sh
#!/bin/bash
# build and run the frame store testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_fb_top -o sim_fb_top
./obj_dir/sim_fb_top | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
